// File: sim.f
+incdir+design
design/cpl_pkg.sv
design/pndg_rd_decode.sv
design/cpl_split_fsm.sv
design/payload_credit.sv
design/tlp_txresp_cntrl.sv
test/tb_txresp.sv

// File: Makefile
.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --assert -f sim.f --top-module tb_txresp -Mdir obj_dir

run: compile
	@out="$$(./obj_dir/Vtb_txresp)"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "test passed"

clean:
	rm -rf obj_dir

// File: test/tb_txresp.sv
`timescale 1ns/1ps

`include "cpl_config.svh"

module tb_txresp;

  import cpl_pkg::*;

  localparam int RCB        = `CPL_RCB_BYTES;
  localparam int BEAT       = `CPL_BEAT_BYTES;
  localparam int FIFO_LIMIT = `CPL_CMD_FIFO_LIMIT;
  localparam int TIMEOUT    = 4000;

  logic                        clk;
  logic                        rst_n;
  logic                        pndg_empty_i;
  pndg_rd_t                    pndg_dat_i;
  logic                        pndg_rd_req_o;
  logic                        rd_data_valid_i;
  logic                        cmd_fifo_busy_i;
  logic [3:0]                  cmd_fifo_usedw_i;
  logic [31:0]                 dev_csr_i;
  cpl_hdr_t                    cpl_hdr_o;
  logic                        cpl_wr_o;
  logic [`CPL_BUFF_ADDR_W-1:0] cpl_ram_wr_addr_o;
  logic                        txresp_idle_o;

  int       seed;
  int       errors;
  int       tests_run;
  int       tests_failed;
  int       beats_owed;
  int       beats_seen;
  int       pending_beats;
  int       sent_bytes;
  int       hdr_bytes;
  int       resp_r;
  logic     slow_data;
  logic     busy_toggle;
  cpl_hdr_t exp_q[$];

  tlp_txresp_cntrl u_dut (
    .AvlClk_i          (clk),
    .Rstn_i            (rst_n),
    .pndg_empty_i      (pndg_empty_i),
    .pndg_dat_i        (pndg_dat_i),
    .pndg_rd_req_o     (pndg_rd_req_o),
    .rd_data_valid_i   (rd_data_valid_i),
    .cmd_fifo_busy_i   (cmd_fifo_busy_i),
    .cmd_fifo_usedw_i  (cmd_fifo_usedw_i),
    .dev_csr_i         (dev_csr_i),
    .cpl_hdr_o         (cpl_hdr_o),
    .cpl_wr_o          (cpl_wr_o),
    .cpl_ram_wr_addr_o (cpl_ram_wr_addr_o),
    .txresp_idle_o     (txresp_idle_o)
  );

  initial
  begin
    clk = 1'b0;
    forever #2 clk = ~clk;
  end

  // one-entry pending-read FIFO and the read data responder
  always @(posedge clk)
  begin
    rd_data_valid_i <= 1'b0;
    if (pndg_rd_req_o)
    begin
      pndg_empty_i <= 1'b1;
      beats_owed   <= beats_owed + pending_beats;
    end
    else if (beats_owed > 0)
    begin
      resp_r = $random(seed);
      if ((slow_data && resp_r[2:0] == 3'b000) || (!slow_data && resp_r[1:0] != 2'b00))
      begin
        rd_data_valid_i <= 1'b1;
        beats_owed      <= beats_owed - 1;
      end
    end
  end

  always @(posedge clk)
  begin
    if (!rst_n)
      beats_seen <= 0;
    else if (rd_data_valid_i)
      beats_seen <= beats_seen + 1;
  end

  // every header against the expected list, and against the data delivered so far
  always @(posedge clk)
  begin
    if (rst_n && cpl_wr_o)
    begin
      if (exp_q.size() == 0)
      begin
        $display("header written at %0t with no completion outstanding", $time);
        errors++;
      end
      else
      begin
        hdr_bytes = int'(exp_q[0].dw_len) * 4;
        assert (cpl_hdr_o == exp_q[0])
        else
        begin
          $display("mismatch at %0t: header %h, expected %h", $time, cpl_hdr_o, exp_q[0]);
          errors++;
        end
        assert (sent_bytes + hdr_bytes <= beats_seen * BEAT)
        else
        begin
          $display("mismatch at %0t: %0d bytes sent with %0d beats delivered", $time,
                   sent_bytes + hdr_bytes, beats_seen);
          errors++;
        end
        sent_bytes = sent_bytes + hdr_bytes;
        void'(exp_q.pop_front());
      end
    end
  end

  a_wr_open: assert property (
    @(posedge clk) disable iff (!rst_n)
    cpl_wr_o |-> (!cmd_fifo_busy_i && cmd_fifo_usedw_i < 4'(FIFO_LIMIT))
  )
  else
  begin
    $display("header written at %0t while the command FIFO was full", $time);
    errors++;
  end

  a_buff_addr: assert property (
    @(posedge clk) disable iff (!rst_n)
    cpl_ram_wr_addr_o == beats_seen[8:0]
  )
  else
  begin
    $display("mismatch at %0t: buffer address %0d, beats %0d", $time, cpl_ram_wr_addr_o,
             beats_seen);
    errors++;
  end

  a_pop_full: assert property (
    @(posedge clk) disable iff (!rst_n)
    pndg_rd_req_o |-> !pndg_empty_i
  )
  else
  begin
    $display("pending FIFO popped at %0t while empty", $time);
    errors++;
  end

  // a request in progress is never reported idle
  a_busy_not_idle: assert property (
    @(posedge clk) disable iff (!rst_n)
    cpl_wr_o |-> !txresp_idle_o
  )
  else
  begin
    $display("mismatch at %0t: idle high during a header write", $time);
    errors++;
  end

  // expected completions of one request, straight from the splitting rules
  task automatic push_expected(input pndg_rd_t w, input int mps);
    int       addr;
    int       rcb;
    int       remaining;
    int       bytes;
    int       offs;
    int       ftrim;
    int       ltrim;
    logic     first;
    cpl_hdr_t h;
    addr      = int'(w.dw_addr) * 4;
    rcb       = RCB - addr;
    remaining = int'(w.dw_len) * 4;
    offs      = 0;
    while (offs < 3 && !w.fbe[offs])
      offs++;
    ftrim = 4 - $countones(w.fbe);
    case (w.lbe)
      4'b0111: ltrim = 1;
      4'b0011: ltrim = 2;
      4'b0001: ltrim = 3;
      default: ltrim = 0;
    endcase
    first = 1'b1;
    while (remaining > 0)
    begin
      if (first)
        bytes = (remaining > rcb) ? rcb : remaining;
      else
        bytes = (remaining > mps) ? mps : remaining;
      h            = '0;
      h.attr       = w.attr;
      h.tc         = w.tc;
      h.one        = 1'b1;
      h.req_id     = w.req_id;
      h.tag        = w.tag;
      h.dw_len     = 9'(bytes / 4);
      h.byte_cnt   = 12'(remaining - (first ? ftrim : 0) - ltrim);
      h.lower_addr = first ? 7'(addr + offs) : 7'd0;
      exp_q.push_back(h);
      remaining = remaining - bytes;
      first     = 1'b0;
    end
  endtask

  task automatic issue_request(input int len, input int dw_addr, input int mps);
    pndg_rd_t w;
    int       r;
    r        = $random(seed);
    w        = '0;
    w.tag    = r[7:0];
    w.req_id = r[23:8];
    w.attr   = r[25:24];
    w.tc     = r[28:26];
    w.dw_len = 11'(len);
    w.dw_addr = 5'(dw_addr);
    case (r[30:29])
      2'd0: w.fbe = 4'b1111;
      2'd1: w.fbe = 4'b1110;
      2'd2: w.fbe = 4'b1100;
      default: w.fbe = 4'b1000;
    endcase
    r = $random(seed);
    case (r[1:0])
      2'd0: w.lbe = 4'b1111;
      2'd1: w.lbe = 4'b0111;
      2'd2: w.lbe = 4'b0011;
      default: w.lbe = 4'b0001;
    endcase
    if (len == 1)
      w.lbe = 4'b0000;
    push_expected(w, mps);
    pending_beats = (len * 4 + BEAT - 1) / BEAT;
    @(posedge clk);
    dev_csr_i    <= (mps == 128) ? 32'h0 : 32'h20;
    pndg_dat_i   <= w;
    pndg_empty_i <= 1'b0;
  endtask

  task automatic wait_done(input string name);
    int cycles;
    cycles = 0;
    while ((exp_q.size() != 0 || beats_owed != 0 || !txresp_idle_o) && cycles < TIMEOUT)
    begin
      @(posedge clk);
      cycles++;
      // three busy cycles out of five, so a ready header meets a busy FIFO
      if (busy_toggle)
        cmd_fifo_busy_i <= ((cycles % 5) < 3);
    end
    if (busy_toggle)
      cmd_fifo_busy_i <= 1'b0;
    if (cycles >= TIMEOUT)
    begin
      $display("timeout: %s did not complete its completions", name);
      $display("test failed");
      $finish;
    end
  endtask

  task automatic end_test(input string name, input int err_before);
    tests_run++;
    if (errors > err_before)
    begin
      tests_failed++;
      $display("%s: FAIL", name);
    end
    else
      $display("%s: PASS", name);
  endtask

  task automatic random_request(input logic split, input int mps);
    int r;
    int dw_addr;
    int room;
    r       = $random(seed);
    dw_addr = int'(r[4:0]);
    room    = 32 - dw_addr;
    if (split)
      issue_request(room + 1 + int'(r[11:5]) % 96, dw_addr, mps);
    else
      issue_request(1 + int'(r[11:5]) % room, dw_addr, mps);
  endtask

  initial
  begin
    int e;
    seed             = 42;
    errors           = 0;
    tests_run        = 0;
    tests_failed     = 0;
    beats_owed       = 0;
    pending_beats    = 0;
    sent_bytes       = 0;
    slow_data        = 1'b0;
    busy_toggle      = 1'b0;
    rst_n            = 1'b0;
    pndg_empty_i     = 1'b1;
    pndg_dat_i       = '0;
    rd_data_valid_i  = 1'b0;
    cmd_fifo_busy_i  = 1'b0;
    cmd_fifo_usedw_i = 4'd0;
    dev_csr_i        = 32'h0;
    repeat (8) @(posedge clk);
    rst_n <= 1'b1;

    e = errors;
    repeat (20)
    begin
      @(posedge clk);
      assert (!pndg_rd_req_o && !cpl_wr_o && txresp_idle_o && cpl_ram_wr_addr_o == '0)
      else
      begin
        $display("mismatch at %0t: outputs not idle after reset", $time);
        errors++;
      end
    end
    end_test("reset and idle", e);

    e = errors;
    repeat (6)
    begin
      random_request(1'b0, 128);
      wait_done("single completion");
    end
    end_test("single completion", e);

    e = errors;
    repeat (4)
    begin
      random_request(1'b1, 128);
      wait_done("splitting at 128");
      random_request(1'b1, 256);
      wait_done("splitting at 256");
    end
    end_test("splitting", e);

    e = errors;
    random_request(1'b1, 128);
    @(posedge clk);
    cmd_fifo_busy_i <= 1'b1;
    repeat (40) @(posedge clk);
    cmd_fifo_busy_i  <= 1'b0;
    cmd_fifo_usedw_i <= 4'd8;
    repeat (40) @(posedge clk);
    cmd_fifo_usedw_i <= 4'd12;
    repeat (20) @(posedge clk);
    cmd_fifo_usedw_i <= 4'd3;
    wait_done("back-pressure");
    // busy also lands while a header waits in a PIPE state
    busy_toggle = 1'b1;
    random_request(1'b1, 256);
    wait_done("back-pressure toggling");
    busy_toggle = 1'b0;
    end_test("back-pressure", e);

    // sparse beats so the headers have to wait for credit
    e = errors;
    slow_data = 1'b1;
    repeat (3)
    begin
      random_request(1'b1, 256);
      wait_done("data credit");
    end
    slow_data = 1'b0;
    end_test("data credit", e);

    $display("tests run %0d, failed %0d, errors %0d", tests_run, tests_failed, errors);
    if (errors == 0 && tests_failed == 0)
      $display("test passed");
    else
      $display("test failed");
    $finish;
  end

endmodule

// File: design/tlp_txresp_cntrl.sv
`timescale 1ns/1ps

`include "cpl_config.svh"

module tlp_txresp_cntrl (
  input  logic                        AvlClk_i,
  input  logic                        Rstn_i,
  input  logic                        pndg_empty_i,
  input  cpl_pkg::pndg_rd_t           pndg_dat_i,
  output logic                        pndg_rd_req_o,
  input  logic                        rd_data_valid_i,
  input  logic                        cmd_fifo_busy_i,
  input  logic [3:0]                  cmd_fifo_usedw_i,
  input  logic [31:0]                 dev_csr_i,
  output cpl_pkg::cpl_hdr_t           cpl_hdr_o,
  output logic                        cpl_wr_o,
  output logic [`CPL_BUFF_ADDR_W-1:0] cpl_ram_wr_addr_o,
  output logic                        txresp_idle_o
);

  import cpl_pkg::*;

  rd_info_t               rd_info;
  logic                   first_cpl;
  logic                   need_load;
  logic [`CPL_BCNT_W-1:0] need_bytes;
  logic                   payload_ok;

  pndg_rd_decode u_decode (
    .pndg_dat_i  (pndg_dat_i),
    .first_cpl_i (first_cpl),
    .info_o      (rd_info)
  );

  cpl_split_fsm u_split (
    .AvlClk_i         (AvlClk_i),
    .Rstn_i           (Rstn_i),
    .pndg_empty_i     (pndg_empty_i),
    .cmd_fifo_busy_i  (cmd_fifo_busy_i),
    .cmd_fifo_usedw_i (cmd_fifo_usedw_i),
    .dev_csr_i        (dev_csr_i),
    .info_i           (rd_info),
    .payload_ok_i     (payload_ok),
    .pndg_rd_req_o    (pndg_rd_req_o),
    .first_cpl_o      (first_cpl),
    .need_load_o      (need_load),
    .need_bytes_o     (need_bytes),
    .cpl_wr_o         (cpl_wr_o),
    .cpl_hdr_o        (cpl_hdr_o),
    .txresp_idle_o    (txresp_idle_o)
  );

  // header write doubles as the credit consume strobe
  payload_credit u_credit (
    .AvlClk_i          (AvlClk_i),
    .Rstn_i            (Rstn_i),
    .rd_data_valid_i   (rd_data_valid_i),
    .need_load_i       (need_load),
    .need_bytes_i      (need_bytes),
    .cpl_sent_i        (cpl_wr_o),
    .payload_ok_o      (payload_ok),
    .cpl_ram_wr_addr_o (cpl_ram_wr_addr_o)
  );

endmodule

// File: design/payload_credit.sv
`timescale 1ns/1ps

`include "cpl_config.svh"

module payload_credit (
  input  logic                        AvlClk_i,
  input  logic                        Rstn_i,
  input  logic                        rd_data_valid_i,
  input  logic                        need_load_i,
  input  logic [`CPL_BCNT_W-1:0]      need_bytes_i,
  input  logic                        cpl_sent_i,
  output logic                        payload_ok_o,
  output logic [`CPL_BUFF_ADDR_W-1:0] cpl_ram_wr_addr_o
);

  localparam int CREDIT_W   = `CPL_CREDIT_W;
  localparam int BEAT_BYTES = `CPL_BEAT_BYTES;
  localparam int WINDOW     = `CPL_CREDIT_WINDOW;

  logic [CREDIT_W-1:0]         limit_q;
  logic [CREDIT_W-1:0]         consumed_q;
  logic [CREDIT_W-1:0]         required_q;
  logic [CREDIT_W-1:0]         avail;
  logic [`CPL_BUFF_ADDR_W-1:0] buff_addr_q;
  logic                        ok_q;

  // all counters wrap, only differences matter
  always_ff @(posedge AvlClk_i or negedge Rstn_i)
  begin
    if (!Rstn_i)
    begin
      limit_q     <= '0;
      consumed_q  <= '0;
      required_q  <= '0;
      buff_addr_q <= '0;
      ok_q        <= 1'b0;
    end
    else
    begin
      if (rd_data_valid_i)
      begin
        limit_q     <= limit_q + CREDIT_W'(BEAT_BYTES);
        buff_addr_q <= buff_addr_q + 1'b1;
      end
      if (cpl_sent_i)
      begin
        consumed_q <= consumed_q + need_bytes_i[CREDIT_W-1:0];
      end
      if (need_load_i)
      begin
        required_q <= consumed_q + need_bytes_i[CREDIT_W-1:0];
      end
      // held low while a new requirement is being loaded
      ok_q <= (avail <= CREDIT_W'(WINDOW)) && !need_load_i;
    end
  end

  assign avail = limit_q - required_q;

  assign payload_ok_o      = ok_q;
  assign cpl_ram_wr_addr_o = buff_addr_q;

  // the splitter only sends once its data has been credited
  a_sent_covered: assert property (
    @(posedge AvlClk_i) disable iff (!Rstn_i)
    cpl_sent_i |-> payload_ok_o
  ) else $error("completion sent without enough returned data");

endmodule

// File: design/cpl_split_fsm.sv
`timescale 1ns/1ps

`include "cpl_config.svh"

module cpl_split_fsm (
  input  logic                   AvlClk_i,
  input  logic                   Rstn_i,
  input  logic                   pndg_empty_i,
  input  logic                   cmd_fifo_busy_i,
  input  logic [3:0]             cmd_fifo_usedw_i,
  input  logic [31:0]            dev_csr_i,
  input  cpl_pkg::rd_info_t      info_i,
  input  logic                   payload_ok_i,
  output logic                   pndg_rd_req_o,
  output logic                   first_cpl_o,
  output logic                   need_load_o,
  output logic [`CPL_BCNT_W-1:0] need_bytes_o,
  output logic                   cpl_wr_o,
  output cpl_pkg::cpl_hdr_t      cpl_hdr_o,
  output logic                   txresp_idle_o
);

  import cpl_pkg::*;

  localparam int BCNT_W     = `CPL_BCNT_W;
  localparam int FIFO_LIMIT = `CPL_CMD_FIFO_LIMIT;

  txresp_state_e     state_q;
  txresp_state_e     state_d;
  rd_info_t          info_q;
  logic              first_q;
  logic [BCNT_W-1:0] curr_bcnt_q;
  logic [BCNT_W-1:0] cpl_bytes_q;
  logic [BCNT_W-1:0] cpl_bytes_d;
  logic [BCNT_W-1:0] remain_q;
  logic [BCNT_W-1:0] max_payload;
  logic [BCNT_W-1:0] rcb_bytes;
  logic              cmd_ok;
  logic              in_pipe;
  logic              send_go;

  // device control max payload size, 000 is 128 bytes
  assign max_payload = (dev_csr_i[7:5] == 3'b000) ? BCNT_W'(128) : BCNT_W'(256);
  assign rcb_bytes   = BCNT_W'(info_q.rcb_bytes);

  assign cmd_ok  = !cmd_fifo_busy_i && (cmd_fifo_usedw_i < 4'(FIFO_LIMIT));
  assign in_pipe = (state_q == PIPE_FIRST) || (state_q == PIPE_MAX) ||
                   (state_q == PIPE_LAST);
  assign send_go = in_pipe && payload_ok_i && cmd_ok;

  always_ff @(posedge AvlClk_i or negedge Rstn_i)
  begin
    if (!Rstn_i)
    begin
      state_q <= IDLE;
    end
    else
    begin
      state_q <= state_d;
    end
  end

  always_comb
  begin
    state_d     = state_q;
    cpl_bytes_d = cpl_bytes_q;
    case (state_q)
      IDLE:
      begin
        if (!pndg_empty_i)
        begin
          state_d = RD_FIFO;
        end
      end
      RD_FIFO:    state_d = LD_BCNT;
      LD_BCNT:    state_d = WAIT_DATA;
      WAIT_DATA:
      begin
        // pick the next completion size, held off while the command FIFO is full
        if (cmd_ok)
        begin
          if (first_q && (curr_bcnt_q > rcb_bytes))
          begin
            state_d     = WAIT_FIRST;
            cpl_bytes_d = rcb_bytes;
          end
          else if (!first_q && (curr_bcnt_q > max_payload))
          begin
            state_d     = WAIT_MAX;
            cpl_bytes_d = max_payload;
          end
          else
          begin
            state_d     = WAIT_LAST;
            cpl_bytes_d = curr_bcnt_q;
          end
        end
      end
      WAIT_FIRST: state_d = PIPE_FIRST;
      WAIT_MAX:   state_d = PIPE_MAX;
      WAIT_LAST:  state_d = PIPE_LAST;
      PIPE_FIRST:
      begin
        if (send_go)
        begin
          state_d = SEND_FIRST;
        end
      end
      PIPE_MAX:
      begin
        if (send_go)
        begin
          state_d = SEND_MAX;
        end
      end
      PIPE_LAST:
      begin
        if (send_go)
        begin
          state_d = SEND_LAST;
        end
      end
      SEND_FIRST: state_d = WAIT_DATA;
      SEND_MAX:   state_d = WAIT_DATA;
      SEND_LAST:  state_d = DONE;
      DONE:       state_d = IDLE;
      default:    state_d = IDLE;
    endcase
  end

  // set for the first completion of each request
  always_ff @(posedge AvlClk_i or negedge Rstn_i)
  begin
    if (!Rstn_i)
    begin
      first_q <= 1'b0;
    end
    else if (state_q == LD_BCNT)
    begin
      first_q <= 1'b1;
    end
    else if (state_q == SEND_FIRST)
    begin
      first_q <= 1'b0;
    end
  end

  // bytes still to be completed for this request
  always_ff @(posedge AvlClk_i or negedge Rstn_i)
  begin
    if (!Rstn_i)
    begin
      curr_bcnt_q <= '0;
    end
    else if (state_q == LD_BCNT)
    begin
      curr_bcnt_q <= info_i.total_bytes;
    end
    else if ((state_q == SEND_FIRST) || (state_q == SEND_MAX) || (state_q == SEND_LAST))
    begin
      curr_bcnt_q <= curr_bcnt_q - cpl_bytes_q;
    end
  end

  // request fields, first trim and lower address only hold for the first completion
  always_ff @(posedge AvlClk_i)
  begin
    if (state_q == LD_BCNT)
    begin
      info_q <= info_i;
    end
    else if (state_q == SEND_FIRST)
    begin
      info_q.first_trim <= 3'd0;
      info_q.lower_addr <= 7'd0;
    end
  end

  always_ff @(posedge AvlClk_i)
  begin
    cpl_bytes_q <= cpl_bytes_d;
    remain_q    <= curr_bcnt_q - BCNT_W'(info_q.first_trim) - BCNT_W'(info_q.last_trim);
  end

  always_comb
  begin
    cpl_hdr_o            = '0;
    cpl_hdr_o.attr       = info_q.attr;
    cpl_hdr_o.dw_len     = cpl_bytes_q[10:2];
    cpl_hdr_o.tc         = info_q.tc;
    cpl_hdr_o.byte_cnt   = remain_q[11:0];
    cpl_hdr_o.one        = 1'b1;
    cpl_hdr_o.req_id     = info_q.req_id;
    cpl_hdr_o.tag        = info_q.tag;
    cpl_hdr_o.lower_addr = info_q.lower_addr;
  end

  assign cpl_wr_o      = send_go;
  assign pndg_rd_req_o = (state_q == RD_FIFO);
  assign first_cpl_o   = (state_q == LD_BCNT) || first_q;
  assign need_load_o   = (state_q == WAIT_FIRST) || (state_q == WAIT_MAX) ||
                         (state_q == WAIT_LAST);
  assign need_bytes_o  = cpl_bytes_q;
  assign txresp_idle_o = (state_q == IDLE) && pndg_empty_i;

  // header writes only go to an open command FIFO
  a_wr_not_busy: assert property (
    @(posedge AvlClk_i) disable iff (!Rstn_i)
    cpl_wr_o |-> !cmd_fifo_busy_i
  ) else $error("header write while the command FIFO is busy");

  a_state_legal: assert property (
    @(posedge AvlClk_i) disable iff (!Rstn_i)
    state_q <= DONE
  ) else $error("splitter state out of range");

endmodule

// File: design/pndg_rd_decode.sv
`timescale 1ns/1ps

`include "cpl_config.svh"

module pndg_rd_decode (
  input  cpl_pkg::pndg_rd_t pndg_dat_i,
  input  logic              first_cpl_i,
  output cpl_pkg::rd_info_t info_o
);

  localparam int RCB_BYTES = `CPL_RCB_BYTES;

  logic [6:0] rd_addr;
  logic [1:0] fbe_offs;
  logic [2:0] first_trim;
  logic [2:0] last_trim;

  // dword aligned low address of the request
  assign rd_addr = {pndg_dat_i.dw_addr, 2'b00};

  // byte offset of the first enabled byte
  always_comb
  begin
    casez (pndg_dat_i.fbe)
      4'b???1: fbe_offs = 2'd0;
      4'b??10: fbe_offs = 2'd1;
      4'b?100: fbe_offs = 2'd2;
      4'b1000: fbe_offs = 2'd3;
      default: fbe_offs = 2'd0;
    endcase
  end

  // disabled bytes in the first dword, only for the first completion
  always_comb
  begin
    if (!first_cpl_i)
    begin
      first_trim = 3'd0;
    end
    else
    begin
      case (pndg_dat_i.fbe)
        4'b0001, 4'b0010, 4'b0100, 4'b1000: first_trim = 3'd3;
        4'b0011, 4'b0110, 4'b1100:          first_trim = 3'd2;
        4'b0111, 4'b1110:                   first_trim = 3'd1;
        default:                            first_trim = 3'd0;
      endcase
    end
  end

  // disabled upper bytes in the last dword
  always_comb
  begin
    case (pndg_dat_i.lbe)
      4'b0111: last_trim = 3'd1;
      4'b0011: last_trim = 3'd2;
      4'b0001: last_trim = 3'd3;
      default: last_trim = 3'd0;
    endcase
  end

  assign info_o.tag         = pndg_dat_i.tag;
  assign info_o.req_id      = pndg_dat_i.req_id;
  assign info_o.attr        = pndg_dat_i.attr;
  assign info_o.tc          = pndg_dat_i.tc;
  assign info_o.total_bytes = {pndg_dat_i.dw_len, 2'b00};
  assign info_o.rcb_bytes   = 8'(RCB_BYTES) - {1'b0, rd_addr};
  assign info_o.lower_addr  = {pndg_dat_i.dw_addr, fbe_offs};
  assign info_o.first_trim  = first_trim;
  assign info_o.last_trim   = last_trim;

  // a multi-dword read always enables at least one byte of its first dword
  always_comb
  begin
    if (pndg_dat_i.dw_len > 11'd1)
    begin
      assert (pndg_dat_i.fbe != 4'b0000)
        else $error("pending read with length %0d has no first byte enable",
                    pndg_dat_i.dw_len);
    end
  end

endmodule

// File: design/cpl_pkg.sv
`include "cpl_config.svh"

package cpl_pkg;

  // word popped from the pending-read FIFO
  typedef struct packed {
    logic        unsup;
    logic [3:0]  lbe;
    logic [2:0]  tc;
    logic [1:0]  attr;
    logic [3:0]  fbe;
    logic [10:0] dw_len;
    logic [15:0] req_id;
    logic        flush;
    logic [4:0]  dw_addr;
    logic [1:0]  rsvd;
    logic [7:0]  tag;
  } pndg_rd_t;

  // request fields after decode
  typedef struct packed {
    logic [7:0]             tag;
    logic [15:0]            req_id;
    logic [1:0]             attr;
    logic [2:0]             tc;
    logic [`CPL_BCNT_W-1:0] total_bytes;
    logic [7:0]             rcb_bytes;
    logic [6:0]             lower_addr;
    logic [2:0]             first_trim;
    logic [2:0]             last_trim;
  } rd_info_t;

  // completion header as written to the command FIFO
  typedef struct packed {
    logic [2:0]  rsvd_hi;
    logic [1:0]  attr;
    logic [8:0]  dw_len;
    logic [2:0]  tc;
    logic [11:0] byte_cnt;
    logic        flush;
    logic        one;
    logic [3:0]  rsvd_mid;
    logic [31:0] rsvd_dw;
    logic        unsup;
    logic [15:0] req_id;
    logic [7:0]  tag;
    logic [6:0]  lower_addr;
  } cpl_hdr_t;

  typedef enum logic [3:0] {
    IDLE, RD_FIFO, LD_BCNT, WAIT_DATA,
    WAIT_FIRST, WAIT_MAX, WAIT_LAST,
    PIPE_FIRST, PIPE_MAX, PIPE_LAST,
    SEND_FIRST, SEND_MAX, SEND_LAST,
    DONE
  } txresp_state_e;

endpackage

// File: design/cpl_config.svh
`ifndef CPL_CONFIG_SVH
`define CPL_CONFIG_SVH

// read completion boundary in bytes
`define CPL_RCB_BYTES 128

// bytes of returned read data per data-valid strobe
`define CPL_BEAT_BYTES 16

// command FIFO counts as full at or above this many used words
`define CPL_CMD_FIFO_LIMIT 8

// widths
`define CPL_BUFF_ADDR_W 9
`define CPL_BCNT_W 13
`define CPL_CREDIT_W 11

// largest wrapped credit difference still taken as enough data
`define CPL_CREDIT_WINDOW 1024

`endif
